/* rtl/cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] word;     // Data word on the internal bus
    typedef logic [3:0]  regIndex; // General register number

    // Instruction word layout
    //   31..27 opcode, 26..23 Ra, 22..19 Rb, 18..15 Rc
    //   18..0  constant C, sign extended to a word
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opSt   = 5'd1,
        opAdd  = 5'd2,
        opSub  = 5'd3,
        opAnd  = 5'd4,
        opOr   = 5'd5,
        opShl  = 5'd6,
        opShr  = 5'd7,
        opAddi = 5'd8,
        opAndi = 5'd9,
        opOri  = 5'd10,
        opMul  = 5'd11,
        opMfhi = 5'd12,
        opMflo = 5'd13,
        opHalt = 5'd14     // Codes above this also stop the core
    } opcode;

    typedef enum logic [3:0] {
        addOp  = 4'd0,
        subOp  = 4'd1,
        andOp  = 4'd2,
        orOp   = 4'd3,
        shlOp  = 4'd4,
        shrOp  = 4'd5,
        mulOp  = 4'd6,
        passOp = 4'd7      // Bus straight through
    } aluOp;

    // Sequencer states, t0 to t2 fetch and t3 to t5 execute
    typedef enum logic [2:0] {
        reset  = 3'd0,
        t0     = 3'd1,
        t1     = 3'd2,
        t2     = 3'd3,
        t3     = 3'd4,
        t4     = 3'd5,
        t5     = 3'd6,
        halted = 3'd7
    } ctrlState;

    // Which register drives the internal bus
    typedef enum logic [2:0] {
        pcSrc    = 3'd0,
        mdrSrc   = 3'd1,
        zLowSrc  = 3'd2,
        zHighSrc = 3'd3,
        hiSrc    = 3'd4,
        loSrc    = 3'd5,
        regSrc   = 3'd6,
        constSrc = 3'd7
    } busSource;

endpackage

/* rtl/alu.sv */
`timescale 1ns/10ps
module alu import cpuPkg::*; (
    input  aluOp        aluOperation,
    input  word         yValue,
    input  word         busData,
    output logic [63:0] aluResult
);

    logic [4:0] shiftAmount;

    assign shiftAmount = busData[4:0];

    always_comb begin
        case (aluOperation)
            addOp: aluResult = {32'b0, yValue + busData};
            subOp: aluResult = {32'b0, yValue - busData};
            andOp: aluResult = {32'b0, yValue & busData};
            orOp:  aluResult = {32'b0, yValue | busData};
            shlOp: aluResult = {32'b0, yValue << shiftAmount};
            shrOp: aluResult = {32'b0, yValue >> shiftAmount};   // Logical
            mulOp: aluResult = $signed(yValue) * $signed(busData);
            default: aluResult = {32'b0, busData};
        endcase
    end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/10ps
module regFile import cpuPkg::*; (
    input  logic    Clock,
    input  logic    rstN,
    input  regIndex regSel,
    input  logic    regLoad,
    input  logic    baOut,
    input  word     busData,
    output word     regData
);

    word regs [16];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (regLoad) begin
            regs[regSel] <= busData;
        end
    end

    // R0 reads as zero only when used as a base
    assign regData = (baOut && regSel == '0) ? '0 : regs[regSel];

endmodule

/* rtl/busRegs.sv */
`timescale 1ns/10ps
module busRegs import cpuPkg::*; #(
    parameter int addrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  busSource             busSel,
    input  logic                 pcLoad,
    input  logic                 incPc,
    input  logic                 marLoad,
    input  logic                 mdrLoad,
    input  logic                 irLoad,
    input  logic                 yLoad,
    input  logic                 zLoad,
    input  logic                 hiLoLoad,
    input  logic [63:0]          aluResult,
    input  word                  datIn,
    input  logic                 mdrFromMem,
    input  word                  regData,
    output word                  ir,
    output word                  busData,
    output word                  yValue,
    output logic [addrWidth-1:0] marAddr,
    output word                  mdrData
);

    word         pc, mdr, hi, lo, cSext;
    logic [63:0] z;

    assign cSext   = {{13{ir[18]}}, ir[18:0]};
    assign mdrData = mdr;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= incPc ? pc + 32'd1 : busData;   // Word addressed
        end
    end

    always_ff @(posedge Clock) begin
        if (irLoad)        ir      <= busData;
        if (marLoad)       marAddr <= busData[addrWidth-1:0];
        if (yLoad)         yValue  <= busData;
        if (zLoad)         z       <= aluResult;
        if (mdrFromMem) begin
            mdr <= datIn;   // Memory word wins
        end else if (mdrLoad) begin
            mdr <= busData;
        end
        if (hiLoLoad) begin
            hi <= z[63:32];
            lo <= z[31:0];
        end
    end

    always_comb begin
        case (busSel)
            pcSrc:    busData = pc;
            mdrSrc:   busData = mdr;
            zLowSrc:  busData = z[31:0];
            zHighSrc: busData = z[63:32];
            hiSrc:    busData = hi;
            loSrc:    busData = lo;
            regSrc:   busData = regData;
            default:  busData = cSext;
        endcase
    end

endmodule

/* rtl/wbMaster.sv */
`timescale 1ns/10ps
module wbMaster import cpuPkg::*; #(
    parameter int addrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic [addrWidth-1:0] marAddr,
    input  word                  mdrData,
    output logic                 memDone,
    output logic                 mdrFromMem,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output logic [addrWidth-1:0] adr,
    output word                  datOut,
    input  word                  datIn,
    input  logic                 ack
);

    // Single classic cycle, held until the slave acks
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            cyc <= 1'b0;
            stb <= 1'b0;
            we  <= 1'b0;
        end else if (cyc && ack) begin
            cyc <= 1'b0;   // Idle for at least one cycle
            stb <= 1'b0;
            we  <= 1'b0;
        end else if (!cyc && (memRead || memWrite)) begin
            cyc <= 1'b1;
            stb <= 1'b1;
            we  <= memWrite;
        end
    end

    always_ff @(posedge Clock) begin
        if (!cyc && (memRead || memWrite)) begin
            adr    <= marAddr;
            datOut <= mdrData;
        end
    end

    assign memDone    = cyc & ack;
    assign mdrFromMem = cyc & ack & ~we;   // datIn is valid with ack

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/10ps
module controlUnit import cpuPkg::*; (
    input  logic     Clock,
    input  logic     rstN,
    input  word      ir,
    input  logic     memDone,
    output busSource busSel,
    output logic     pcLoad,
    output logic     incPc,
    output logic     marLoad,
    output logic     mdrLoad,
    output logic     irLoad,
    output logic     yLoad,
    output logic     zLoad,
    output logic     hiLoLoad,
    output logic     regLoad,
    output regIndex  regSel,
    output logic     baOut,
    output aluOp     aluOperation,
    output logic     memRead,
    output logic     memWrite,
    output logic     halted
);

    ctrlState   state, nextState;
    logic [1:0] step, nextStep;   // Sub-steps of t1 and of memory t5
    opcode      op;
    regIndex    ra, rb, rc;
    aluOp       aluSel;
    logic       useConst;

    assign op = opcode'(ir[31:27]);
    assign ra = ir[26:23];
    assign rb = ir[22:19];
    assign rc = ir[18:15];

    assign halted = (state == cpuPkg::halted);

    // ALU function and second operand per opcode
    always_comb begin
        useConst = 1'b0;
        case (op)
            opAdd:  aluSel = addOp;
            opSub:  aluSel = subOp;
            opAnd:  aluSel = andOp;
            opOr:   aluSel = orOp;
            opShl:  aluSel = shlOp;
            opShr:  aluSel = shrOp;
            opMul:  aluSel = mulOp;
            opAddi, opLd, opSt: begin
                aluSel   = addOp;   // Also forms base plus C
                useConst = 1'b1;
            end
            opAndi: begin
                aluSel   = andOp;
                useConst = 1'b1;
            end
            opOri: begin
                aluSel   = orOp;
                useConst = 1'b1;
            end
            default: aluSel = passOp;
        endcase
    end

    always_comb begin
        busSel       = pcSrc;
        pcLoad       = 1'b0;
        incPc        = 1'b0;
        marLoad      = 1'b0;
        mdrLoad      = 1'b0;
        irLoad       = 1'b0;
        yLoad        = 1'b0;
        zLoad        = 1'b0;
        hiLoLoad     = 1'b0;
        regLoad      = 1'b0;
        regSel       = ra;
        baOut        = 1'b0;
        aluOperation = passOp;
        memRead      = 1'b0;
        memWrite     = 1'b0;
        nextState    = state;
        nextStep     = step;
        case (state)
            reset: nextState = t0;
            t0: begin
                marLoad   = 1'b1;   // PC to MAR, PC plus one
                pcLoad    = 1'b1;
                incPc     = 1'b1;
                nextState = t1;
            end
            t1: begin
                if (step == 2'd0) begin
                    memRead  = 1'b1;
                    nextStep = 2'd1;
                end else if (memDone) begin
                    nextState = t2;
                end
            end
            t2: begin
                busSel    = mdrSrc;
                irLoad    = 1'b1;
                nextState = t3;
            end
            t3: begin
                case (op)
                    opMfhi, opMflo: begin
                        busSel    = (op == opMfhi) ? hiSrc : loSrc;
                        regLoad   = 1'b1;
                        nextState = t0;
                    end
                    opMul: begin
                        busSel    = regSrc;   // Ra into Y
                        yLoad     = 1'b1;
                        nextState = t4;
                    end
                    opAdd, opSub, opAnd, opOr, opShl, opShr,
                    opAddi, opAndi, opOri, opLd, opSt: begin
                        busSel    = regSrc;
                        regSel    = rb;
                        baOut     = (op == opLd) || (op == opSt);
                        yLoad     = 1'b1;
                        nextState = t4;
                    end
                    default: nextState = cpuPkg::halted;
                endcase
            end
            t4: begin
                aluOperation = aluSel;
                zLoad        = 1'b1;
                if (useConst) begin
                    busSel = constSrc;
                end else begin
                    busSel = regSrc;
                    regSel = (op == opMul) ? rb : rc;
                end
                nextState = t5;
            end
            t5: begin
                if (op == opMul) begin
                    hiLoLoad  = 1'b1;   // Z pair into HI and LO
                    nextState = t0;
                end else if (op == opLd || op == opSt) begin
                    case (step)
                        2'd0: begin
                            busSel   = zLowSrc;   // Effective address
                            marLoad  = 1'b1;
                            nextStep = 2'd1;
                        end
                        2'd1: begin
                            if (op == opLd) begin
                                memRead = 1'b1;
                            end else begin
                                busSel  = regSrc;   // Store data into MDR
                                mdrLoad = 1'b1;
                            end
                            nextStep = 2'd2;
                        end
                        2'd2: begin
                            if (op == opSt) begin
                                memWrite = 1'b1;
                                nextStep = 2'd3;
                            end else if (memDone) begin
                                nextStep = 2'd3;
                            end
                        end
                        default: begin
                            if (op == opLd) begin
                                busSel    = mdrSrc;
                                regLoad   = 1'b1;
                                nextState = t0;
                            end else if (memDone) begin
                                nextState = t0;
                            end
                        end
                    endcase
                end else begin
                    busSel    = zLowSrc;
                    regLoad   = 1'b1;
                    nextState = t0;
                end
            end
            default: nextState = cpuPkg::halted;   // Stays until reset
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= reset;
            step  <= 2'd0;
        end else begin
            state <= nextState;
            step  <= (nextState != state) ? 2'd0 : nextStep;
        end
    end

endmodule

/* rtl/cpuTop.sv */
`timescale 1ns/10ps
module cpuTop import cpuPkg::*; #(
    parameter int addrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 rstN,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output logic [addrWidth-1:0] adr,
    output word                  datOut,
    input  word                  datIn,
    input  logic                 ack,
    output logic                 halted
);

    busSource             busSel;
    aluOp                 aluOperation;
    regIndex              regSel;
    word                  ir, busData, regData, yValue, mdrData;
    logic [63:0]          aluResult;
    logic [addrWidth-1:0] marAddr;
    logic pcLoad, incPc, marLoad, mdrLoad, irLoad, yLoad, zLoad;
    logic hiLoLoad, regLoad, baOut;
    logic memRead, memWrite, memDone, mdrFromMem;

    controlUnit controlUnit_inst (
        .Clock(Clock), .rstN(rstN), .ir(ir), .memDone(memDone),
        .busSel(busSel), .pcLoad(pcLoad), .incPc(incPc), .marLoad(marLoad),
        .mdrLoad(mdrLoad), .irLoad(irLoad), .yLoad(yLoad), .zLoad(zLoad),
        .hiLoLoad(hiLoLoad), .regLoad(regLoad), .regSel(regSel), .baOut(baOut),
        .aluOperation(aluOperation), .memRead(memRead), .memWrite(memWrite),
        .halted(halted)
    );

    busRegs #(.addrWidth(addrWidth)) busRegs_inst (
        .Clock(Clock), .rstN(rstN), .busSel(busSel), .pcLoad(pcLoad),
        .incPc(incPc), .marLoad(marLoad), .mdrLoad(mdrLoad), .irLoad(irLoad),
        .yLoad(yLoad), .zLoad(zLoad), .hiLoLoad(hiLoLoad), .aluResult(aluResult),
        .datIn(datIn), .mdrFromMem(mdrFromMem), .regData(regData), .ir(ir),
        .busData(busData), .yValue(yValue), .marAddr(marAddr), .mdrData(mdrData)
    );

    regFile regFile_inst (
        .Clock(Clock), .rstN(rstN), .regSel(regSel), .regLoad(regLoad),
        .baOut(baOut), .busData(busData), .regData(regData)
    );

    alu alu_inst (
        .aluOperation(aluOperation), .yValue(yValue), .busData(busData),
        .aluResult(aluResult)
    );

    wbMaster #(.addrWidth(addrWidth)) wbMaster_inst (
        .Clock(Clock), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
        .marAddr(marAddr), .mdrData(mdrData), .memDone(memDone),
        .mdrFromMem(mdrFromMem), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datOut(datOut), .datIn(datIn), .ack(ack)
    );

endmodule

/* testbench/cpuAssert.sv */
`timescale 1ns/10ps
module cpuAssert import cpuPkg::*; #(
    parameter int addrWidth = 10
) (
    input logic                 Clock,
    input logic                 rstN,
    input logic                 cyc,
    input logic                 stb,
    input logic                 we,
    input logic [addrWidth-1:0] adr,
    input word                  datOut,
    input logic                 ack
);

    int failures = 0;   // Count of failed properties

    stbInsideCyc: assert property (@(posedge Clock) disable iff (!rstN) stb |-> cyc)
        else begin
            failures++;
            $error("stb high outside a bus cycle");
        end

    // Classic cycle holds address, direction and data until ack
    heldUntilAck: assert property (@(posedge Clock) disable iff (!rstN)
        (stb && !ack) |=> ($stable(adr) && $stable(we) && $stable(datOut)))
        else begin
            failures++;
            $error("adr, we or datOut changed before ack");
        end

    // Bus is idle on the first edge after reset is released
    idleAfterReset: assert property (@(posedge Clock) $rose(rstN) |-> (!cyc && !stb))
        else begin
            failures++;
            $error("cyc or stb high after reset");
        end

endmodule

bind wbMaster cpuAssert #(.addrWidth(addrWidth)) cpuAssert_inst (
    .Clock(Clock), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datOut(datOut), .ack(ack)
);

/* testbench/cpuChecker.sv */
`timescale 1ns/10ps
module cpuChecker import cpuPkg::*; #(
    parameter int addrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic                 ack,
    input  logic [addrWidth-1:0] adr,
    input  word                  datOut,
    input  logic                 halted,
    output int                   mismatchCount,
    output int                   failCount,
    output logic                 finished
);

    word                  image [1024];
    logic [addrWidth-1:0] expAdr [256];
    word                  expDat [256];
    int                   expCount, expReads, storeIndex, readCount, haltCycles;
    bit                   refReady, haltSeen, lateCycle, haltDropped;

    // ISA model of the program image, records every store in order
    function automatic void runReference();
        word                  regs [16];
        word                  hi, lo, pc, inst, cExt, base;
        logic [63:0]          product;
        logic [addrWidth-1:0] ea;
        regIndex              ra, rb, rc;
        bit                   running;
        int                   steps;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        hi       = '0;
        lo       = '0;
        pc       = '0;
        running  = 1'b1;
        steps    = 0;
        expCount = 0;
        expReads = 0;
        while (running && steps < 4096) begin
            inst = image[pc[addrWidth-1:0]];
            pc   = pc + 1;
            steps++;
            expReads++;   // Instruction fetch
            ra   = inst[26:23];
            rb   = inst[22:19];
            rc   = inst[18:15];
            cExt = {{13{inst[18]}}, inst[18:0]};
            base = (rb == 4'd0) ? '0 : regs[rb];   // R0 base means absolute
            ea   = addrWidth'(base + cExt);
            case (opcode'(inst[31:27]))
                opLd: begin
                    regs[ra] = image[ea];
                    expReads++;
                end
                opSt: begin
                    image[ea]        = regs[ra];
                    expAdr[expCount] = ea;
                    expDat[expCount] = regs[ra];
                    expCount++;
                end
                opAdd:  regs[ra] = regs[rb] + regs[rc];
                opSub:  regs[ra] = regs[rb] - regs[rc];
                opAnd:  regs[ra] = regs[rb] & regs[rc];
                opOr:   regs[ra] = regs[rb] | regs[rc];
                opShl:  regs[ra] = regs[rb] << regs[rc][4:0];
                opShr:  regs[ra] = regs[rb] >> regs[rc][4:0];
                opAddi: regs[ra] = regs[rb] + cExt;
                opAndi: regs[ra] = regs[rb] & cExt;
                opOri:  regs[ra] = regs[rb] | cExt;
                opMul: begin
                    // Low 64 bits of the extended product are the signed result
                    product = {{32{regs[ra][31]}}, regs[ra]} *
                              {{32{regs[rb][31]}}, regs[rb]};
                    hi      = product[63:32];
                    lo      = product[31:0];
                end
                opMfhi: regs[ra] = hi;
                opMflo: regs[ra] = lo;
                default: running = 1'b0;   // halt and unused codes
            endcase
        end
    endfunction

    initial begin
        @(posedge rstN);
        for (int i = 0; i < 1024; i++) begin
            image[i] = cpuTb.mem[i];
        end
        runReference();
        refReady = 1'b1;
    end

    always @(posedge Clock) begin
        if (!rstN) begin
            finished <= 1'b0;
        end else if (refReady) begin
            if (cyc && stb && ack && we) begin
                if (storeIndex >= expCount) begin
                    $display("Unexpected extra store to address %h at %0t", adr, $time);
                    failCount++;
                end else if (adr !== expAdr[storeIndex] || datOut !== expDat[storeIndex]) begin
                    $display("mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, storeIndex, datOut, adr, expDat[storeIndex],
                             expAdr[storeIndex]);
                    mismatchCount++;
                end
                storeIndex++;
            end else if (cyc && stb && ack) begin
                readCount++;
            end
            if (halted) begin
                if (!haltSeen) begin
                    haltSeen = 1'b1;
                    if (storeIndex != expCount) begin
                        $display("Processor halted after %0d of %0d stores", storeIndex, expCount);
                        failCount++;
                    end
                    if (readCount != expReads) begin
                        $display("Processor made %0d reads where %0d were due", readCount,
                                 expReads);
                        failCount++;
                    end
                end
                if (cyc && !lateCycle) begin
                    $display("A bus cycle started after halt at %0t", $time);
                    failCount++;
                    lateCycle = 1'b1;
                end
                haltCycles++;
                if (haltCycles == 20) finished <= 1'b1;
            end else if (haltSeen && !haltDropped) begin
                $display("halted went low again at %0t", $time);
                failCount++;
                haltDropped = 1'b1;
            end
        end
    end

endmodule

/* testbench/cpuTb.sv */
`timescale 1ns/10ps
module cpuTb import cpuPkg::*; ();

    localparam int addrWidth      = 10;
    localparam int dataBase       = 512;   // Initial register values
    localparam int resultBase     = 768;   // Where the stores land
    localparam int randomCount    = 40;
    localparam int resetCycles    = 16;
    localparam int cyclesPerInstr = 60;

    logic                 Clock, rstN, cyc, stb, we, ack, halted, finished;
    logic [addrWidth-1:0] adr;
    word                  datOut, datIn;
    word                  mem [1024];
    logic [15:0]          lfsrState;
    int                   programLength, waitLeft, cycleCount, timeoutLimit;
    int                   mismatchCount, failCount, assertFails;
    bit                   inCycle, timedOut;

    cpuTop #(.addrWidth(addrWidth)) cpuTop_inst (
        .Clock(Clock), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datOut(datOut), .datIn(datIn), .ack(ack), .halted(halted)
    );

    cpuChecker #(.addrWidth(addrWidth)) cpuChecker_inst (
        .Clock(Clock), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .ack(ack),
        .adr(adr), .datOut(datOut), .halted(halted), .mismatchCount(mismatchCount),
        .failCount(failCount), .finished(finished)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // Galois LFSR with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic word randomBits(input int count);
        word value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};   // One step per bit
            lfsrState = lfsrStep(lfsrState);
        end
        return value;
    endfunction

    function automatic word encode(input opcode op, input regIndex ra, input regIndex rb,
                                   input logic [18:0] low);
        return {op, ra, rb, low};
    endfunction

    task automatic placeWord(input word value);
        mem[programLength] = value;
        programLength++;
    endtask

    task automatic buildProgram();
        int      pick, emitted;
        bit      mulDone;
        opcode   op;
        regIndex ra, rb, rc;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hF000_0000 | (i * 32'h0001_0003);   // Decodes as halt
        end
        for (int r = 0; r < 16; r++) begin
            mem[dataBase + r] = randomBits(32);
        end
        mem[dataBase + 16] = dataBase + 24;     // Base pointer for the loads
        mem[dataBase + 17] = resultBase + 48;   // Base pointer for the last stores
        programLength = 0;
        // Loads through R15 with negative offsets, then R15 itself
        placeWord(encode(opLd, 4'd15, 4'd0, 19'(dataBase + 16)));
        for (int r = 0; r < 15; r++) begin
            placeWord(encode(opLd, regIndex'(r), 4'd15, 19'(r - 24)));
        end
        placeWord(encode(opLd, 4'd15, 4'd0, 19'(dataBase + 15)));
        emitted = 0;
        mulDone = 1'b0;
        while (emitted < randomCount) begin
            pick = int'(randomBits(4)) % 12;
            ra   = regIndex'(randomBits(4));
            rb   = regIndex'(randomBits(4));
            rc   = regIndex'(randomBits(4));
            if ((pick == 10 || pick == 11) && !mulDone) pick = 9;   // HI and LO still empty
            if (pick == 9 && emitted > randomCount - 3) pick = 0;
            case (pick)
                1:       op = opSub;
                2:       op = opAnd;
                3:       op = opOr;
                4:       op = opShl;
                5:       op = opShr;
                6:       op = opAddi;
                7:       op = opAndi;
                8:       op = opOri;
                10:      op = opMfhi;
                11:      op = opMflo;
                default: op = opAdd;
            endcase
            if (pick >= 6 && pick <= 8) begin
                placeWord(encode(op, ra, rb, 19'(randomBits(19))));
                emitted++;
            end else if (pick == 9) begin
                placeWord(encode(opMul, ra, rb, '0));   // Both halves read back
                placeWord(encode(opMfhi, rc, 4'd0, '0));
                placeWord(encode(opMflo, regIndex'(randomBits(4)), 4'd0, '0));
                emitted += 3;
                mulDone = 1'b1;
            end else begin
                placeWord(encode(op, ra, rb, {rc, 15'd0}));
                emitted++;
            end
        end
        for (int r = 0; r < 16; r++) begin
            placeWord(encode(opSt, regIndex'(r), 4'd0, 19'(resultBase + r)));
        end
        placeWord(encode(opLd, 4'd14, 4'd0, 19'(dataBase + 17)));
        for (int r = 0; r < 4; r++) begin
            placeWord(encode(opSt, regIndex'(r), 4'd14, 19'(r - 32)));
        end
        placeWord(encode(opHalt, 4'd0, 4'd0, '0));
    endtask

    // Memory slave with 0 to 3 wait states per cycle
    always @(posedge Clock) begin
        if (!rstN) begin
            ack     <= 1'b0;
            inCycle = 1'b0;
        end else if (ack) begin
            ack <= 1'b0;   // Master ends the cycle on this edge
        end else if (cyc && stb) begin
            if (!inCycle) begin
                inCycle  = 1'b1;
                waitLeft = int'(randomBits(2));
            end
            if (waitLeft == 0) begin
                ack     <= 1'b1;
                inCycle = 1'b0;
                if (we) begin
                    mem[adr] <= datOut;
                end else begin
                    datIn <= mem[adr];
                end
            end else begin
                waitLeft--;
            end
        end
    end

    initial begin
        rstN      = 1'b0;
        ack       = 1'b0;
        datIn     = '0;
        lfsrState = 16'd3121;
        buildProgram();
        timeoutLimit = resetCycles + cyclesPerInstr * programLength + 40;
        repeat (resetCycles) @(posedge Clock);
        rstN <= 1'b1;
        cycleCount = resetCycles;
        while (!finished && cycleCount < timeoutLimit) begin
            @(posedge Clock);
            cycleCount++;
        end
        if (!finished) begin
            $display("Timeout: the processor never halted within %0d cycles", timeoutLimit);
            timedOut = 1'b1;
        end
        assertFails = cpuTop_inst.wbMaster_inst.cpuAssert_inst.failures;
        $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatchCount, failCount + int'(timedOut), assertFails);
        if (mismatchCount + failCount + assertFails + int'(timedOut) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/cpuPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/busRegs.sv
rtl/wbMaster.sv
rtl/controlUnit.sv
rtl/cpuTop.sv
testbench/cpuAssert.sv
testbench/cpuChecker.sv
testbench/cpuTb.sv
